// ==== verilog/tlb_pkg.sv ====
package tlb_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ps_t;

    // one half of an even/odd page pair
    typedef struct packed {
        ppn_t       ppn;
        plv_t       plv;
        logic [1:0] mat;
        logic       d;
        logic       v;
    } tlb_page_t;

    typedef struct packed {
        logic      e;
        vppn_t     vppn;
        asid_t     asid;
        logic      g;
        ps_t       ps;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef enum logic [2:0] {
        INV_ALL0              = 3'd0,
        INV_ALL1              = 3'd1,
        INV_GLOBAL            = 3'd2,
        INV_NONGLOBAL         = 3'd3,
        INV_ASID              = 3'd4,
        INV_ASID_VA           = 3'd5,
        INV_GLOBAL_OR_ASID_VA = 3'd6
    } inv_op_e;

    typedef enum logic [2:0] {
        EC_NONE    = 3'd0,
        EC_REFILL  = 3'd1,
        EC_INVALID = 3'd2,
        EC_PRIV    = 3'd3,
        EC_MODIFY  = 3'd4
    } ecode_e;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2,
        CMD_INV   = 2'd3
    } apb_cmd_e;

    typedef struct packed {
        logic       we;
        logic [7:0] index;
        tlb_entry_t entry;
    } tlb_w_req_t;

    typedef struct packed {
        logic    en;
        inv_op_e op;
        asid_t   asid;
        vppn_t   vpn;
    } tlb_inv_req_t;

    typedef struct packed {
        vaddr_t vaddr;
        asid_t  asid;
    } tlb_s_req_t;

    typedef struct packed {
        logic       hit;
        logic [7:0] index;
        ps_t        ps;
        tlb_page_t  page;
    } tlb_s_resp_t;

    typedef struct packed {
        vaddr_t vaddr;
        asid_t  asid;
        plv_t   plv;
        logic   store;
    } xlat_req_t;

    typedef struct packed {
        paddr_t     paddr;
        logic [1:0] mat;
        ecode_e     ecode;
    } xlat_resp_t;

    // apb register offsets
    localparam logic [7:0] REG_CMD   = 8'h00;
    localparam logic [7:0] REG_INDEX = 8'h04;
    localparam logic [7:0] REG_EHI   = 8'h08;
    localparam logic [7:0] REG_EMISC = 8'h0C;
    localparam logic [7:0] REG_ELO0  = 8'h10;
    localparam logic [7:0] REG_ELO1  = 8'h14;
    localparam logic [7:0] REG_INVVA = 8'h18;

endpackage

// ==== verilog/tlb_lookup.sv ====
`timescale 1ns/1ps

module tlb_lookup #(
    parameter int TLB_ENTRY_NUM = 16
) (
    input  tlb_pkg::tlb_entry_t [TLB_ENTRY_NUM-1:0] entries_i,
    input  tlb_pkg::tlb_s_req_t                     req_i,
    output tlb_pkg::tlb_s_resp_t                    resp_o
);

    logic [TLB_ENTRY_NUM-1:0] match;
    logic [TLB_ENTRY_NUM-1:0] odd;

    for (genvar i = 0; i < TLB_ENTRY_NUM; i++) begin : g_match
        logic small_pg;
        logic vpn_hit;

        assign small_pg = (entries_i[i].ps == 6'd12);
        // 2 MiB pairs only compare the upper vppn bits
        assign vpn_hit  = small_pg ? (entries_i[i].vppn == req_i.vaddr[31:13])
                                   : (entries_i[i].vppn[18:10] == req_i.vaddr[31:23]);
        assign match[i] = entries_i[i].e && vpn_hit &&
                          (entries_i[i].g || (entries_i[i].asid == req_i.asid));
        assign odd[i]   = small_pg ? req_i.vaddr[12] : req_i.vaddr[21];
    end

    // entries are one-hot, so an or-style merge is enough
    always_comb begin
        resp_o = '0;
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            if (match[i]) begin
                resp_o.hit   = 1'b1;
                resp_o.index = 8'(i);
                resp_o.ps    = entries_i[i].ps;
                resp_o.page  = odd[i] ? entries_i[i].page1 : entries_i[i].page0;
            end
        end
    end

    // software must never load overlapping entries
    always_comb begin
        if (!$isunknown(match)) begin
            assert ($onehot0(match))
                else $error("tlb_lookup: more than one entry hits");
        end
    end

endmodule

// ==== verilog/tlb.sv ====
`timescale 1ns/1ps

module tlb #(
    parameter int TLB_ENTRY_NUM = 16,
    parameter int TLB_PORT      = 2
) (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  tlb_pkg::tlb_s_req_t  [TLB_PORT-1:0]    s_req_i,
    output tlb_pkg::tlb_s_resp_t [TLB_PORT-1:0]    s_resp_o,
    input  tlb_pkg::tlb_w_req_t                    w_req_i,
    input  logic [$clog2(TLB_ENTRY_NUM)-1:0]       r_index_i,
    output tlb_pkg::tlb_entry_t                    r_entry_o,
    input  tlb_pkg::tlb_inv_req_t                  inv_req_i
);

    localparam int IDX_W = $clog2(TLB_ENTRY_NUM);

    tlb_pkg::tlb_entry_t [TLB_ENTRY_NUM-1:0] store_q;
    tlb_pkg::tlb_entry_t [TLB_ENTRY_NUM-1:0] entries;
    logic [TLB_ENTRY_NUM-1:0]                e_q;
    logic [TLB_ENTRY_NUM-1:0]                inv_sel;
    logic [IDX_W-1:0]                        w_idx;

    function automatic logic va_match(tlb_pkg::tlb_entry_t ent, tlb_pkg::vppn_t vpn);
        if (ent.ps == 6'd12) begin
            return ent.vppn == vpn;
        end
        return ent.vppn[18:10] == vpn[18:10];
    endfunction

    assign w_idx = w_req_i.index[IDX_W-1:0];

    // valid bits live apart from the entry payload
    always_comb begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            entries[i]   = store_q[i];
            entries[i].e = e_q[i];
        end
    end

    assign r_entry_o = entries[r_index_i];

    always_ff @(posedge clk) begin
        if (w_req_i.we) begin
            store_q[w_idx] <= w_req_i.entry;
        end
    end

    // which entries the invalidate op hits
    always_comb begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            case (inv_req_i.op)
                tlb_pkg::INV_ALL0,
                tlb_pkg::INV_ALL1:      inv_sel[i] = 1'b1;
                tlb_pkg::INV_GLOBAL:    inv_sel[i] = store_q[i].g;
                tlb_pkg::INV_NONGLOBAL: inv_sel[i] = !store_q[i].g;
                tlb_pkg::INV_ASID: begin
                    inv_sel[i] = !store_q[i].g && (store_q[i].asid == inv_req_i.asid);
                end
                tlb_pkg::INV_ASID_VA: begin
                    inv_sel[i] = !store_q[i].g && (store_q[i].asid == inv_req_i.asid) &&
                                 va_match(store_q[i], inv_req_i.vpn);
                end
                tlb_pkg::INV_GLOBAL_OR_ASID_VA: begin
                    inv_sel[i] = (store_q[i].g || (store_q[i].asid == inv_req_i.asid)) &&
                                 va_match(store_q[i], inv_req_i.vpn);
                end
                default:                inv_sel[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
                if (w_req_i.we && (w_idx == IDX_W'(i))) begin
                    e_q[i] <= w_req_i.entry.e;
                end else if (inv_req_i.en && inv_sel[i]) begin
                    e_q[i] <= 1'b0;
                end
            end
        end
    end

    // searches read the pre-edge contents
    for (genvar p = 0; p < TLB_PORT; p++) begin : g_port
        tlb_lookup #(
            .TLB_ENTRY_NUM (TLB_ENTRY_NUM)
        ) u_lookup (
            .entries_i (entries),
            .req_i     (s_req_i[p]),
            .resp_o    (s_resp_o[p])
        );
    end

    // the controller issues one command at a time
    ap_one_cmd: assert property (@(posedge clk) disable iff (reset_i)
        !(w_req_i.we && inv_req_i.en));

endmodule

// ==== verilog/tlb_apb_ctrl.sv ====
`timescale 1ns/1ps

module tlb_apb_ctrl #(
    parameter int TLB_ENTRY_NUM = 16
) (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               psel_i,
    input  logic                               penable_i,
    input  logic                               pwrite_i,
    input  logic [7:0]                         paddr_i,
    input  logic [31:0]                        pwdata_i,
    output logic [31:0]                        prdata_o,
    output logic                               pready_o,
    output logic                               pslverr_o,
    output tlb_pkg::tlb_w_req_t                w_req_o,
    output tlb_pkg::tlb_inv_req_t              inv_req_o,
    output logic [$clog2(TLB_ENTRY_NUM)-1:0]   r_index_o,
    input  tlb_pkg::tlb_entry_t                r_entry_i
);

    localparam int IDX_W = $clog2(TLB_ENTRY_NUM);

    tlb_pkg::apb_cmd_e   cmd;
    logic                wr_acc;
    logic                cmd_wr;
    logic                we_q;
    logic                inv_en_q;
    logic                rd_pend_q;
    tlb_pkg::inv_op_e    inv_op_q;
    tlb_pkg::asid_t      inv_asid_q;
    tlb_pkg::vppn_t      invva_q;
    logic [IDX_W-1:0]    index_q;
    tlb_pkg::tlb_entry_t stage_q;

    // elo layout: v 0, d 1, plv 3:2, mat 5:4, ppn 27:8
    function automatic tlb_pkg::tlb_page_t elo_unpack(logic [31:0] w);
        tlb_pkg::tlb_page_t pg;
        pg.v   = w[0];
        pg.d   = w[1];
        pg.plv = w[3:2];
        pg.mat = w[5:4];
        pg.ppn = w[27:8];
        return pg;
    endfunction

    function automatic logic [31:0] elo_pack(tlb_pkg::tlb_page_t pg);
        return {4'b0, pg.ppn, 2'b0, pg.mat, pg.plv, pg.d, pg.v};
    endfunction

    assign wr_acc    = psel_i && penable_i && pwrite_i;
    assign cmd       = tlb_pkg::apb_cmd_e'(pwdata_i[1:0]);
    assign pslverr_o = wr_acc && (paddr_i == tlb_pkg::REG_CMD) && (pwdata_i[6:4] == 3'd7);
    assign cmd_wr    = wr_acc && (paddr_i == tlb_pkg::REG_CMD) && !pslverr_o;
    assign pready_o  = 1'b1;

    // strobes live for the one cycle after the access phase
    always_ff @(posedge clk) begin
        if (reset_i) begin
            we_q      <= 1'b0;
            inv_en_q  <= 1'b0;
            rd_pend_q <= 1'b0;
        end else begin
            we_q      <= cmd_wr && (cmd == tlb_pkg::CMD_WRITE);
            inv_en_q  <= cmd_wr && (cmd == tlb_pkg::CMD_INV);
            rd_pend_q <= cmd_wr && (cmd == tlb_pkg::CMD_READ);
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            inv_op_q   <= tlb_pkg::inv_op_e'(pwdata_i[6:4]);
            inv_asid_q <= pwdata_i[25:16];
        end
    end

    // staging registers, refilled by the read command
    always_ff @(posedge clk) begin
        if (rd_pend_q) begin
            stage_q <= r_entry_i;
        end else if (wr_acc) begin
            case (paddr_i)
                tlb_pkg::REG_INDEX: index_q <= pwdata_i[IDX_W-1:0];
                tlb_pkg::REG_EHI:   stage_q.vppn <= pwdata_i[31:13];
                tlb_pkg::REG_EMISC: begin
                    stage_q.e    <= pwdata_i[0];
                    stage_q.g    <= pwdata_i[1];
                    stage_q.ps   <= pwdata_i[13:8];
                    stage_q.asid <= pwdata_i[25:16];
                end
                tlb_pkg::REG_ELO0:  stage_q.page0 <= elo_unpack(pwdata_i);
                tlb_pkg::REG_ELO1:  stage_q.page1 <= elo_unpack(pwdata_i);
                tlb_pkg::REG_INVVA: invva_q <= pwdata_i[31:13];
                default:            ;
            endcase
        end
    end

    always_comb begin
        case (paddr_i)
            tlb_pkg::REG_INDEX: prdata_o = 32'(index_q);
            tlb_pkg::REG_EHI:   prdata_o = {stage_q.vppn, 13'b0};
            tlb_pkg::REG_EMISC: begin
                prdata_o = {6'b0, stage_q.asid, 2'b0, stage_q.ps, 6'b0, stage_q.g, stage_q.e};
            end
            tlb_pkg::REG_ELO0:  prdata_o = elo_pack(stage_q.page0);
            tlb_pkg::REG_ELO1:  prdata_o = elo_pack(stage_q.page1);
            tlb_pkg::REG_INVVA: prdata_o = {invva_q, 13'b0};
            default:            prdata_o = '0;
        endcase
    end

    assign w_req_o   = '{we: we_q, index: 8'(index_q), entry: stage_q};
    assign inv_req_o = '{en: inv_en_q, op: inv_op_q, asid: inv_asid_q, vpn: invva_q};
    assign r_index_o = index_q;

    // setup phase always leads into a zero-wait access
    ap_no_wait: assert property (@(posedge clk) disable iff (reset_i)
        (psel_i && !penable_i) |=> (psel_i && penable_i && pready_o));

endmodule

// ==== verilog/xlat_pipe.sv ====
`timescale 1ns/1ps

module xlat_pipe (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  tlb_pkg::xlat_req_t    req_i,
    output logic                  resp_valid_o,
    input  logic                  resp_ready_i,
    output tlb_pkg::xlat_resp_t   resp_o,
    output tlb_pkg::tlb_s_req_t   s_req_o,
    input  tlb_pkg::tlb_s_resp_t  s_resp_i
);

    logic                 stall;
    logic                 s1_valid_q;
    logic                 s2_valid_q;
    tlb_pkg::xlat_req_t   s1_req_q;
    tlb_pkg::xlat_req_t   s2_req_q;
    tlb_pkg::tlb_s_resp_t s2_srch_q;
    tlb_pkg::tlb_page_t   page;
    tlb_pkg::ecode_e      ecode;
    tlb_pkg::paddr_t      paddr;

    // a stalled output freezes the whole pipe
    assign stall       = resp_valid_o && !resp_ready_i;
    assign req_ready_o = !stall;

    // stage 1 drives the search
    assign s_req_o = '{vaddr: s1_req_q.vaddr, asid: s1_req_q.asid};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid_q   <= 1'b0;
            s2_valid_q   <= 1'b0;
            resp_valid_o <= 1'b0;
        end else if (!stall) begin
            s1_valid_q   <= req_valid_i;
            s2_valid_q   <= s1_valid_q;
            resp_valid_o <= s2_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (req_valid_i) begin
                s1_req_q <= req_i;
            end
            s2_req_q  <= s1_req_q;
            s2_srch_q <= s_resp_i;
            resp_o    <= '{paddr: paddr, mat: page.mat, ecode: ecode};
        end
    end

    assign page = s2_srch_q.page;

    // stage 2 checks, in fault priority order
    always_comb begin
        if (!s2_srch_q.hit) begin
            ecode = tlb_pkg::EC_REFILL;
        end else if (!page.v) begin
            ecode = tlb_pkg::EC_INVALID;
        end else if (s2_req_q.plv > page.plv) begin
            ecode = tlb_pkg::EC_PRIV;
        end else if (s2_req_q.store && !page.d) begin
            ecode = tlb_pkg::EC_MODIFY;
        end else begin
            ecode = tlb_pkg::EC_NONE;
        end

        if (s2_srch_q.ps == 6'd12) begin
            paddr = {page.ppn, s2_req_q.vaddr[11:0]};
        end else begin
            paddr = {page.ppn[19:9], s2_req_q.vaddr[20:0]};
        end
        if (ecode != tlb_pkg::EC_NONE) begin
            paddr = '0;
        end
    end

    // a request that is not taken stays put until it is
    ap_req_hold: assert property (@(posedge clk) disable iff (reset_i)
        (req_valid_i && !req_ready_o) |=> (req_valid_i && $stable(req_i)));

endmodule

// ==== verilog/tlb_mmu_top.sv ====
`timescale 1ns/1ps

module tlb_mmu_top #(
    parameter int TLB_ENTRY_NUM = 16,
    parameter int TLB_PORT      = 2
) (
    input  logic                                 clk,
    input  logic                                 reset_i,
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    input  logic                                 pwrite_i,
    input  logic [7:0]                           paddr_i,
    input  logic [31:0]                          pwdata_i,
    output logic [31:0]                          prdata_o,
    output logic                                 pready_o,
    output logic                                 pslverr_o,
    input  logic [TLB_PORT-1:0]                  req_valid_i,
    output logic [TLB_PORT-1:0]                  req_ready_o,
    input  tlb_pkg::xlat_req_t [TLB_PORT-1:0]    req_i,
    output logic [TLB_PORT-1:0]                  resp_valid_o,
    input  logic [TLB_PORT-1:0]                  resp_ready_i,
    output tlb_pkg::xlat_resp_t [TLB_PORT-1:0]   resp_o
);

    tlb_pkg::tlb_w_req_t                  w_req;
    tlb_pkg::tlb_inv_req_t                inv_req;
    logic [$clog2(TLB_ENTRY_NUM)-1:0]     r_index;
    tlb_pkg::tlb_entry_t                  r_entry;
    tlb_pkg::tlb_s_req_t  [TLB_PORT-1:0]  s_req;
    tlb_pkg::tlb_s_resp_t [TLB_PORT-1:0]  s_resp;

    tlb_apb_ctrl #(
        .TLB_ENTRY_NUM (TLB_ENTRY_NUM)
    ) u_ctrl (
        .clk       (clk),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .w_req_o   (w_req),
        .inv_req_o (inv_req),
        .r_index_o (r_index),
        .r_entry_i (r_entry)
    );

    tlb #(
        .TLB_ENTRY_NUM (TLB_ENTRY_NUM),
        .TLB_PORT      (TLB_PORT)
    ) u_tlb (
        .clk       (clk),
        .reset_i   (reset_i),
        .s_req_i   (s_req),
        .s_resp_o  (s_resp),
        .w_req_i   (w_req),
        .r_index_i (r_index),
        .r_entry_o (r_entry),
        .inv_req_i (inv_req)
    );

    // port 0 fetch, port 1 data
    for (genvar p = 0; p < TLB_PORT; p++) begin : g_chan
        xlat_pipe u_pipe (
            .clk          (clk),
            .reset_i      (reset_i),
            .req_valid_i  (req_valid_i[p]),
            .req_ready_o  (req_ready_o[p]),
            .req_i        (req_i[p]),
            .resp_valid_o (resp_valid_o[p]),
            .resp_ready_i (resp_ready_i[p]),
            .resp_o       (resp_o[p]),
            .s_req_o      (s_req[p]),
            .s_resp_i     (s_resp[p])
        );
    end

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for 10 rising edges
    initial begin
        reset_o = 1'b1;
        repeat (10) @(posedge clk);
        reset_o <= 1'b0;
    end

endmodule

// ==== tb/tb_tlb_mmu.sv ====
`timescale 1ns/1ps

module tb_tlb_mmu;

    logic                       clk;
    logic                       reset;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [7:0]                 paddr;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic                       pready;
    logic                       pslverr;
    logic [1:0]                 req_valid;
    logic [1:0]                 req_ready;
    tlb_pkg::xlat_req_t [1:0]   req;
    logic [1:0]                 resp_valid;
    logic [1:0]                 resp_ready;
    tlb_pkg::xlat_resp_t [1:0]  resp;

    int    seed = 6312;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    err_mark;
    string tname;

    // invalidate fixture, all 4 KiB pairs
    logic [31:0] fx_va   [5] = '{32'h0040_0000, 32'h0040_0000, 32'h0080_0000,
                                 32'h00C0_0000, 32'h0100_0000};
    logic [9:0]  fx_asid [5] = '{10'd1, 10'd2, 10'd0, 10'd1, 10'd0};
    logic        fx_g    [5] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

    tb_clkgen u_clk (
        .clk     (clk),
        .reset_o (reset)
    );

    tlb_mmu_top #(
        .TLB_ENTRY_NUM (16),
        .TLB_PORT      (2)
    ) dut0 (
        .clk          (clk),
        .reset_i      (reset),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_i        (req),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_o       (resp)
    );

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", tname, what, exp, act);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR in %s: %s", tname, msg);
    endtask

    task automatic begin_test(input string name);
        tname = name;
        err_mark = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            $display("test %s: ok", tname);
        end else begin
            tests_failed++;
            $display("test %s: failed", tname);
        end
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check("pready", 32'd1, 32'(pready));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check("pslverr", 32'd0, 32'(err));
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic command(input logic [1:0] cmd, input logic [2:0] op, input logic [9:0] asid,
                           output logic err);
        logic [31:0] unused;
        apb_access(1'b1, tlb_pkg::REG_CMD, {6'b0, asid, 9'b0, op, 2'b0, cmd}, unused, err);
        repeat (2) @(posedge clk);
    endtask

    function automatic logic [31:0] elo(logic [19:0] ppn, logic [1:0] plv, logic [1:0] mat,
                                        logic d, logic v);
        return {4'b0, ppn, 2'b0, mat, plv, d, v};
    endfunction

    task automatic program_entry(input int idx, input logic [31:0] va, input logic [9:0] asid,
                                 input logic g, input logic [5:0] ps,
                                 input logic [31:0] elo0, input logic [31:0] elo1);
        logic err;
        apb_write(tlb_pkg::REG_INDEX, 32'(idx));
        apb_write(tlb_pkg::REG_EHI, {va[31:13], 13'b0});
        apb_write(tlb_pkg::REG_EMISC, {6'b0, asid, 2'b0, ps, 6'b0, g, 1'b1});
        apb_write(tlb_pkg::REG_ELO0, elo0);
        apb_write(tlb_pkg::REG_ELO1, elo1);
        command(2'd1, 3'd0, 10'd0, err);
        check("write pslverr", 32'd0, 32'(err));
    endtask

    task automatic translate(input int p, input logic [31:0] va, input logic [9:0] asid,
                             input logic [1:0] plv, input logic st,
                             output tlb_pkg::xlat_resp_t r);
        int n;
        @(posedge clk);
        req_valid[p] <= 1'b1;
        req[p]       <= '{vaddr: va, asid: asid, plv: plv, store: st};
        n = 0;
        @(negedge clk);
        while (!req_ready[p] && n < 100) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        req_valid[p] <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!resp_valid[p] && n < 100) begin
            @(negedge clk);
            n++;
        end
        r = resp[p];
        if (!resp_valid[p]) begin
            report_problem("translation got no response");
        end
    endtask

    task automatic xlat_check(input string what, input int p, input logic [31:0] va,
                              input logic [9:0] asid, input logic [1:0] plv, input logic st,
                              input logic [31:0] exp_pa, input int exp_ec, input int exp_mat);
        tlb_pkg::xlat_resp_t r;
        translate(p, va, asid, plv, st, r);
        check({what, " paddr"}, exp_pa, r.paddr);
        check({what, " ecode"}, 32'(exp_ec), 32'(r.ecode));
        if (exp_ec == 0) begin
            check({what, " mat"}, 32'(exp_mat), 32'(r.mat));
        end
    endtask

    function automatic logic [31:0] pa_4k(logic [19:0] ppn, logic [31:0] va);
        return {ppn, va[11:0]};
    endfunction

    function automatic logic [31:0] pa_2m(logic [19:0] ppn, logic [31:0] va);
        return {ppn[19:9], va[20:0]};
    endfunction

    // entries cleared by each invalidate op
    function automatic logic inv_selects(int op, logic g, logic [9:0] asid, logic [31:0] va,
                                         logic [9:0] ia, logic [31:0] iva);
        case (op)
            0, 1: return 1'b1;
            2: return g;
            3: return !g;
            4: return !g && asid == ia;
            5: return !g && asid == ia && va[31:13] == iva[31:13];
            6: return (g || asid == ia) && va[31:13] == iva[31:13];
            default: return 1'b0;
        endcase
    endfunction

    task automatic load_hit_entries();
        logic err;
        command(2'd3, 3'd0, 10'd0, err);
        program_entry(0, 32'h2468_A000, 10'd1, 1'b0, 6'd12,
                      elo(20'h11111, 2'd3, 2'd1, 1'b1, 1'b1),
                      elo(20'h22222, 2'd3, 2'd2, 1'b1, 1'b1));
        program_entry(1, 32'h8000_0000, 10'd7, 1'b1, 6'd21,
                      elo(20'h33200, 2'd3, 2'd1, 1'b1, 1'b1),
                      elo(20'h44600, 2'd3, 2'd1, 1'b1, 1'b1));
    endtask

    task automatic test_write_read();
        logic [31:0] ehi;
        logic [31:0] emisc;
        logic [31:0] lo0;
        logic [31:0] lo1;
        logic [31:0] rd;
        logic        err;
        begin_test("write_read");
        ehi   = $random(seed) & 32'hFFFF_E000;
        rd    = $random(seed);
        emisc = {6'b0, rd[9:0], 2'b0, (rd[10] ? 6'd12 : 6'd21), 6'b0, rd[11], rd[12]};
        lo0   = $random(seed) & 32'h0FFF_FF3F;
        lo1   = $random(seed) & 32'h0FFF_FF3F;
        apb_write(tlb_pkg::REG_INDEX, 32'd5);
        apb_write(tlb_pkg::REG_EHI, ehi);
        apb_write(tlb_pkg::REG_EMISC, emisc);
        apb_write(tlb_pkg::REG_ELO0, lo0);
        apb_write(tlb_pkg::REG_ELO1, lo1);
        command(2'd1, 3'd0, 10'd0, err);
        // scribble over the staging copy first
        apb_write(tlb_pkg::REG_EHI, 32'd0);
        apb_write(tlb_pkg::REG_EMISC, 32'd0);
        apb_write(tlb_pkg::REG_ELO0, 32'd0);
        apb_write(tlb_pkg::REG_ELO1, 32'd0);
        command(2'd2, 3'd0, 10'd0, err);
        apb_read(tlb_pkg::REG_INDEX, rd);
        check("index", 32'd5, rd);
        apb_read(tlb_pkg::REG_EHI, rd);
        check("ehi", ehi, rd);
        apb_read(tlb_pkg::REG_EMISC, rd);
        check("emisc", emisc, rd);
        apb_read(tlb_pkg::REG_ELO0, rd);
        check("elo0", lo0, rd);
        apb_read(tlb_pkg::REG_ELO1, rd);
        check("elo1", lo1, rd);
        end_test();
    endtask

    task automatic test_hits();
        logic [31:0] va;
        logic [31:0] off;
        begin_test("hits");
        load_hit_entries();
        for (int p = 0; p < 2; p++) begin
            off = $random(seed);
            va  = 32'h2468_A000 | off[11:0];
            xlat_check("4k even", p, va, 10'd1, 2'd0, 1'b0, pa_4k(20'h11111, va), 0, 1);
            va  = 32'h2468_B000 | off[11:0];
            xlat_check("4k odd", p, va, 10'd1, 2'd0, 1'b1, pa_4k(20'h22222, va), 0, 2);
            va  = 32'h8000_0000 | off[20:0];
            xlat_check("2m even", p, va, 10'd7, 2'd0, 1'b0, pa_2m(20'h33200, va), 0, 1);
            va  = 32'h8020_0000 | off[20:0];
            xlat_check("2m odd", p, va, 10'd7, 2'd0, 1'b1, pa_2m(20'h44600, va), 0, 1);
        end
        end_test();
    endtask

    task automatic test_faults();
        begin_test("faults");
        load_hit_entries();
        program_entry(2, 32'h3000_0000, 10'd1, 1'b0, 6'd12,
                      elo(20'h55555, 2'd0, 2'd0, 1'b1, 1'b0),
                      elo(20'h66666, 2'd0, 2'd0, 1'b0, 1'b1));
        xlat_check("unmapped", 0, 32'h1000_0000, 10'd1, 2'd0, 1'b0, 32'd0, 1, 0);
        xlat_check("asid miss", 1, 32'h2468_A010, 10'd2, 2'd0, 1'b0, 32'd0, 1, 0);
        xlat_check("global", 1, 32'h8000_0123, 10'h3FF, 2'd0, 1'b0,
                   pa_2m(20'h33200, 32'h8000_0123), 0, 1);
        xlat_check("invalid", 0, 32'h3000_0040, 10'd1, 2'd0, 1'b0, 32'd0, 2, 0);
        xlat_check("priv", 1, 32'h3000_1040, 10'd1, 2'd3, 1'b0, 32'd0, 3, 0);
        xlat_check("modify", 1, 32'h3000_1040, 10'd1, 2'd0, 1'b1, 32'd0, 4, 0);
        end_test();
    endtask

    task automatic load_inv_fixture();
        for (int i = 0; i < 5; i++) begin
            program_entry(i, fx_va[i], fx_asid[i], fx_g[i], 6'd12,
                          elo(20'(i + 1), 2'd3, 2'd0, 1'b1, 1'b1),
                          elo(20'(i + 1), 2'd3, 2'd0, 1'b1, 1'b1));
        end
    endtask

    task automatic test_invalidate();
        logic err;
        logic gone;
        begin_test("invalidate");
        command(2'd3, 3'd0, 10'd0, err);
        apb_write(tlb_pkg::REG_INVVA, fx_va[0]);
        for (int op = 0; op < 8; op++) begin
            load_inv_fixture();
            command(2'd3, 3'(op), 10'd1, err);
            check($sformatf("op%0d pslverr", op), 32'(op == 7), 32'(err));
            for (int i = 0; i < 5; i++) begin
                gone = inv_selects(op, fx_g[i], fx_asid[i], fx_va[i], 10'd1, fx_va[0]);
                xlat_check($sformatf("op%0d entry%0d", op, i), i % 2, fx_va[i], fx_asid[i],
                           2'd0, 1'b0, gone ? 32'd0 : pa_4k(20'(i + 1), fx_va[i]),
                           gone ? 1 : 0, 0);
            end
        end
        end_test();
    endtask

    function automatic logic [31:0] bp_va(int p, int k);
        return 32'h2468_A000 | (32'(k & 1) << 12) | (32'(k) << 4) | (32'(p) << 8);
    endfunction

    task automatic test_backpressure();
        tlb_pkg::xlat_resp_t got0[$];
        tlb_pkg::xlat_resp_t got1[$];
        logic [31:0]         va;
        int                  n_drv;
        int                  n_col;
        begin_test("backpressure");
        load_hit_entries();
        @(posedge clk);
        resp_ready <= 2'b00;
        fork
            begin
                for (int k = 0; k < 4; k++) begin
                    @(posedge clk);
                    req_valid <= 2'b11;
                    for (int p = 0; p < 2; p++) begin
                        req[p] <= '{vaddr: bp_va(p, k), asid: 10'd1, plv: 2'd0, store: 1'b0};
                    end
                    n_drv = 0;
                    @(negedge clk);
                    while (req_ready != 2'b11 && n_drv < 100) begin
                        @(negedge clk);
                        n_drv++;
                    end
                end
                @(posedge clk);
                req_valid <= 2'b00;
            end
            begin
                repeat (11) @(posedge clk);
                @(negedge clk);
                check("ready while stalled", 32'd0, 32'(req_ready));
                @(posedge clk);
                resp_ready <= 2'b11;
            end
            begin
                n_col = 0;
                while ((got0.size() < 4 || got1.size() < 4) && n_col < 300) begin
                    @(negedge clk);
                    n_col++;
                    if (resp_valid[0] && resp_ready[0]) got0.push_back(resp[0]);
                    if (resp_valid[1] && resp_ready[1]) got1.push_back(resp[1]);
                end
            end
        join
        repeat (5) @(negedge clk);
        check("leftover valid", 32'd0, 32'(resp_valid));
        check("count ch0", 32'd4, got0.size());
        check("count ch1", 32'd4, got1.size());
        for (int k = 0; k < 4 && k < got0.size() && k < got1.size(); k++) begin
            va = bp_va(0, k);
            check($sformatf("ch0 item%0d", k),
                  pa_4k((k & 1) ? 20'h22222 : 20'h11111, va), got0[k].paddr);
            va = bp_va(1, k);
            check($sformatf("ch1 item%0d", k),
                  pa_4k((k & 1) ? 20'h22222 : 20'h11111, va), got1[k].paddr);
        end
        end_test();
    endtask

    // five tests come to roughly 1400 cycles together
    initial begin
        repeat (5000) @(posedge clk);
        $display("ERROR: watchdog expired, run did not finish");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        req_valid  = '0;
        req        = '0;
        resp_ready = 2'b11;
        @(negedge reset);
        repeat (2) @(posedge clk);
        test_write_read();
        test_hits();
        test_faults();
        test_invalidate();
        test_backpressure();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tlb_mmu.f ====
verilog/tlb_pkg.sv
verilog/tlb_lookup.sv
verilog/tlb.sv
verilog/tlb_apb_ctrl.sv
verilog/xlat_pipe.sv
verilog/tlb_mmu_top.sv
tb/tb_clkgen.sv
tb/tb_tlb_mmu.sv
